//--- verilog/irq_pkg.sv
// Machine mode only; lines 3, 7, 11 and 16 to 31 exist and all others read as zero
`default_nettype none

package irq_pkg;

  ////////////////////////////////////////
  // Widths and vector types
  ////////////////////////////////////////

  // Number of interrupt lines in mip and mie
  localparam int unsigned IRQ_NUM = 32;

  typedef logic [IRQ_NUM-1:0] irq_vec_t;
  typedef logic [4:0]         irq_id_t;
  typedef logic [11:0]        csr_addr_t;
  typedef logic [31:0]        csr_data_t;

  ////////////////////////////////////////
  // CSR numbers and bit positions
  ////////////////////////////////////////

  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MIE     = 12'h304;
  localparam csr_addr_t CSR_MIP     = 12'h344;

  // mstatus interrupt enable and its saved copy
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;

  // Standard machine lines
  localparam int unsigned IRQ_MSI = 3;
  localparam int unsigned IRQ_MTI = 7;
  localparam int unsigned IRQ_MEI = 11;
  // First of the platform fast lines
  localparam int unsigned IRQ_FAST_LO = 16;

  // Implemented lines 31 to 16, 11, 7 and 3
  localparam irq_vec_t IRQ_MASK = 32'hFFFF_0888;

  ////////////////////////////////////////
  // CSR port payloads (OBI style)
  ////////////////////////////////////////

  typedef struct packed {
    logic      we;
    csr_addr_t addr;
    csr_data_t wdata;
  } csr_req_t;

  typedef struct packed {
    csr_data_t rdata;
    logic      err;
  } csr_resp_t;

endpackage

`default_nettype wire

//--- verilog/irq_pending.sv
// Lines are level sensitive and sampled once per cycle with no extra synchronizer stage
`default_nettype none

module irq_pending (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  irq_pkg::irq_vec_t irq_i,
  output irq_pkg::irq_vec_t mip_o
);
  import irq_pkg::*;

  // Sampled lines held as the mip CSR
  irq_vec_t mip_q;
  irq_vec_t mip_d;

  ////////////////////////////////////////
  // Line capture
  ////////////////////////////////////////

  // Unimplemented positions never become pending
  assign mip_d = irq_i & IRQ_MASK;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mip_q <= '0;
    end else begin
      // Follows the lines with one cycle of delay
      mip_q <= mip_d;
    end
  end

  // Read by the CSR block and the priority logic
  assign mip_o = mip_q;

endmodule

`default_nettype wire

//--- verilog/irq_csr.sv
// One CSR transfer in flight at most; grant is withheld in acknowledge and response cycles
`default_nettype none

module irq_csr (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               csr_req_i,
  input  irq_pkg::csr_req_t  csr_req_payload_i,
  output logic               csr_gnt_o,
  output logic               csr_rvalid_o,
  output irq_pkg::csr_resp_t csr_resp_o,
  input  irq_pkg::irq_vec_t  mip_i,
  input  logic               trap_taken_i,
  output irq_pkg::irq_vec_t  mie_o,
  output logic               m_ie_o
);
  import irq_pkg::*;

  logic      active_q;
  logic      rvalid_q;
  logic      accept;
  logic      wr_mie;
  logic      wr_mstatus;
  irq_vec_t  mie_q;
  logic      m_ie_q;
  logic      m_pie_q;
  csr_data_t mstatus_rdata;
  csr_resp_t resp_d;
  csr_resp_t resp_q;

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  // No grant in reset, during trap entry or while a response is due
  assign csr_gnt_o = active_q && !rvalid_q && !trap_taken_i;
  assign accept    = csr_req_i && csr_gnt_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      // Out of reset after the first edge
      active_q <= 1'b1;
      // Response exactly one cycle after acceptance
      rvalid_q <= accept;
    end
  end

  ////////////////////////////////////////
  // Read decode
  ////////////////////////////////////////

  always_comb begin
    mstatus_rdata                   = '0;
    mstatus_rdata[MSTATUS_MIE_BIT]  = m_ie_q;
    mstatus_rdata[MSTATUS_MPIE_BIT] = m_pie_q;
    resp_d                          = '0;
    case (csr_req_payload_i.addr)
      CSR_MSTATUS: resp_d.rdata = mstatus_rdata;
      CSR_MIE:     resp_d.rdata = mie_q;
      CSR_MIP:     resp_d.rdata = mip_i;
      // Unknown number gives err with zero data
      default:     resp_d.err   = 1'b1;
    endcase
  end

  // Response payload loaded only on acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_q <= resp_d;
    end
  end

  ////////////////////////////////////////
  // CSR storage and trap entry
  ////////////////////////////////////////

  // mip writes fall through without effect
  assign wr_mie     = accept && csr_req_payload_i.we && (csr_req_payload_i.addr == CSR_MIE);
  assign wr_mstatus = accept && csr_req_payload_i.we && (csr_req_payload_i.addr == CSR_MSTATUS);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mie_q   <= '0;
      m_ie_q  <= 1'b0;
      m_pie_q <= 1'b0;
    end else begin
      if (wr_mie) begin
        mie_q <= csr_req_payload_i.wdata & IRQ_MASK;
      end
      // Trap entry saves MIE and disables
      if (trap_taken_i) begin
        m_pie_q <= m_ie_q;
        m_ie_q  <= 1'b0;
      end else if (wr_mstatus) begin
        m_ie_q  <= csr_req_payload_i.wdata[MSTATUS_MIE_BIT];
        m_pie_q <= csr_req_payload_i.wdata[MSTATUS_MPIE_BIT];
      end
    end
  end

  assign csr_rvalid_o = rvalid_q;
  assign csr_resp_o   = resp_q;
  assign mie_o        = mie_q;
  assign m_ie_o       = m_ie_q;

endmodule

`default_nettype wire

//--- verilog/irq_controller.sv
// Fixed priority 31..16, 11, 3, 7; one acknowledge per trap until software sets MIE again
`default_nettype none

module irq_controller (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  irq_pkg::irq_vec_t mip_i,
  input  irq_pkg::irq_vec_t mie_i,
  input  logic              m_ie_i,
  output logic              irq_ack_o,
  output irq_pkg::irq_id_t  irq_id_o
);
  import irq_pkg::*;

  irq_vec_t irq_take;
  logic     irq_wanted;
  logic     ack_d;
  logic     ack_q;
  irq_id_t  irq_id_d;
  irq_id_t  irq_id_q;

  ////////////////////////////////////////
  // Pending and enabled
  ////////////////////////////////////////

  assign irq_take = mip_i & mie_i;

  // Globally gated by mstatus.MIE
  assign irq_wanted = m_ie_i && (|irq_take);

  ////////////////////////////////////////
  // Priority encoder
  ////////////////////////////////////////

  // Lowest priority first so a later match overrides
  always_comb begin
    irq_id_d = '0;
    if (irq_take[IRQ_MTI]) begin
      irq_id_d = irq_id_t'(IRQ_MTI);
    end
    if (irq_take[IRQ_MSI]) begin
      irq_id_d = irq_id_t'(IRQ_MSI);
    end
    if (irq_take[IRQ_MEI]) begin
      irq_id_d = irq_id_t'(IRQ_MEI);
    end
    // Fast lines with 31 winning
    for (int i = IRQ_FAST_LO; i < IRQ_NUM; i++) begin
      if (irq_take[i]) begin
        irq_id_d = irq_id_t'(i);
      end
    end
  end

  ////////////////////////////////////////
  // Acknowledge
  ////////////////////////////////////////

  // Single cycle pulse and never back to back
  assign ack_d = irq_wanted && !ack_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= ack_d;
    end
  end

  // Id captured with the pulse
  always_ff @(posedge clk_i) begin
    if (ack_d) begin
      irq_id_q <= irq_id_d;
    end
  end

  assign irq_ack_o = ack_q;
  assign irq_id_o  = irq_id_q;

endmodule

`default_nettype wire

//--- verilog/irq_top.sv
// Machine-mode interrupt block; irq_id_o is only meaningful while irq_ack_o is high
`default_nettype none

module irq_top (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  irq_pkg::irq_vec_t  irq_i,
  input  logic               csr_req_i,
  input  irq_pkg::csr_req_t  csr_req_payload_i,
  output logic               csr_gnt_o,
  output logic               csr_rvalid_o,
  output irq_pkg::csr_resp_t csr_resp_o,
  output logic               irq_ack_o,
  output irq_pkg::irq_id_t   irq_id_o
);
  import irq_pkg::*;

  irq_vec_t mip;
  irq_vec_t mie;
  logic     m_ie;

  ////////////////////////////////////////
  // Capture and CSR storage
  ////////////////////////////////////////

  irq_pending u_irq_pending (
    .clk_i    ( clk_i    ),
    .arst_n_i ( arst_n_i ),
    .irq_i    ( irq_i    ),
    .mip_o    ( mip      )
  );

  // Acknowledge doubles as trap-taken
  irq_csr u_irq_csr (
    .clk_i             ( clk_i             ),
    .arst_n_i          ( arst_n_i          ),
    .csr_req_i         ( csr_req_i         ),
    .csr_req_payload_i ( csr_req_payload_i ),
    .csr_gnt_o         ( csr_gnt_o         ),
    .csr_rvalid_o      ( csr_rvalid_o      ),
    .csr_resp_o        ( csr_resp_o        ),
    .mip_i             ( mip               ),
    .trap_taken_i      ( irq_ack_o         ),
    .mie_o             ( mie               ),
    .m_ie_o            ( m_ie              )
  );

  ////////////////////////////////////////
  // Priority and acknowledge
  ////////////////////////////////////////

  irq_controller u_irq_controller (
    .clk_i     ( clk_i     ),
    .arst_n_i  ( arst_n_i  ),
    .mip_i     ( mip       ),
    .mie_i     ( mie       ),
    .m_ie_i    ( m_ie      ),
    .irq_ack_o ( irq_ack_o ),
    .irq_id_o  ( irq_id_o  )
  );

endmodule

`default_nettype wire

//--- tb/irq_properties.sv
// Bound into irq_csr, whose trap_taken_i is the controller's acknowledge
`default_nettype none

module irq_properties (
  input logic clk_i,
  input logic arst_n_i,
  input logic req_i,
  input logic gnt_i,
  input logic rvalid_i,
  input logic ack_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Acknowledge is a single-cycle pulse
  ack_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i) ack_i |=> !ack_i)
    else $error("Acknowledge high for two cycles");

  // Response only in the cycle after acceptance
  rvalid_slot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rvalid_i |-> $past(req_i && gnt_i))
    else $error("rvalid without an accepted request");

  // Trap entry blocks the CSR port
  gnt_vs_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i) !(gnt_i && ack_i))
    else $error("Grant given in an acknowledge cycle");

endmodule

bind irq_csr irq_properties u_irq_properties (
  .clk_i    ( clk_i        ),
  .arst_n_i ( arst_n_i     ),
  .req_i    ( csr_req_i    ),
  .gnt_i    ( csr_gnt_o    ),
  .rvalid_i ( csr_rvalid_o ),
  .ack_i    ( trap_taken_i )
);

`default_nettype wire

//--- tb/irq_tb.sv
// irq_i changes only while mstatus.MIE is clear; each CSR transfer fits the watchdog budget
`default_nettype none

module irq_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import irq_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 5;
  localparam int N_RW         = 20;
  localparam int N_PRIO       = 40;
  localparam int ACK_WAIT     = 8;
  // Planned transfers with XFER_CYCLES each including wait windows
  localparam int N_XFERS      = 4 * N_RW + 3 * N_PRIO + 24;
  localparam int XFER_CYCLES  = 16;

  typedef struct packed {
    logic    take;
    irq_id_t id;
  } ack_ref_t;

  logic        clk = 1'b0;
  logic        arst_n;
  irq_vec_t    irq;
  logic        csr_req;
  csr_req_t    csr_req_payload;
  logic        csr_gnt;
  logic        csr_rvalid;
  csr_resp_t   csr_resp;
  logic        irq_ack;
  irq_id_t     irq_id;
  // Reference copies of mie and mstatus
  irq_vec_t    impl_mask;
  irq_vec_t    mdl_mie;
  logic        mdl_m_ie;
  logic        mdl_m_pie;
  logic [31:0] lcg_state;
  int          errors = 0;
  int          checks = 0;
  int          acks_seen = 0;
  int          xfers = 0;
  int          responses = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  irq_top u_irq_top (
    .clk_i             ( clk             ),
    .arst_n_i          ( arst_n          ),
    .irq_i             ( irq             ),
    .csr_req_i         ( csr_req         ),
    .csr_req_payload_i ( csr_req_payload ),
    .csr_gnt_o         ( csr_gnt         ),
    .csr_rvalid_o      ( csr_rvalid      ),
    .csr_resp_o        ( csr_resp        ),
    .irq_ack_o         ( irq_ack         ),
    .irq_id_o          ( irq_id          )
  );

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Fast lines high to low, then external, software, timer
  function automatic ack_ref_t predict_ack(irq_vec_t lines, irq_vec_t en, logic m_ie);
    int unsigned order [19] = '{31, 30, 29, 28, 27, 26, 25, 24, 23, 22, 21, 20, 19, 18, 17, 16,
                                11, 3, 7};
    irq_vec_t    hit;
    ack_ref_t    r;
    logic        found;
    hit    = lines & impl_mask & en;
    r      = '0;
    found  = 1'b0;
    r.take = m_ie && (hit != '0);
    for (int k = 0; k < 19; k++) begin
      if (hit[order[k]] && !found) begin
        r.id  = irq_id_t'(order[k]);
        found = 1'b1;
      end
    end
    return r;
  endfunction

  function automatic csr_data_t mstatus_model();
    csr_data_t v;
    v    = '0;
    v[3] = mdl_m_ie;
    v[7] = mdl_m_pie;
    return v;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (exp == got) else begin
      errors++;
      $display("ERROR %s: expected %h, got %h", name, exp, got);
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    checks++;
    assert (cond) else begin
      errors++;
      $display("%s at %0t ns", msg, $time);
    end
  endtask

  ////////////////////////////////////////
  // CSR port
  ////////////////////////////////////////

  // Called on a falling edge; grant is registered and settled there
  task automatic transfer(input logic we, input csr_addr_t addr, input csr_data_t wdata,
                          input csr_data_t exp_rdata, input logic exp_err, output int stall);
    stall                 = 0;
    csr_req               = 1'b1;
    csr_req_payload.we    = we;
    csr_req_payload.addr  = addr;
    csr_req_payload.wdata = wdata;
    while (!csr_gnt) begin
      @(negedge clk);
      stall++;
    end
    @(negedge clk);
    csr_req         = 1'b0;
    csr_req_payload = '0;
    while (!csr_rvalid) begin
      @(negedge clk);
    end
    xfers++;
    check_val("csr_resp_o.err", 32'(exp_err), 32'(csr_resp.err));
    if (!we || exp_err) begin
      check_val("csr_resp_o.rdata", exp_rdata, csr_resp.rdata);
    end
  endtask

  task automatic read_reg(input csr_addr_t addr, input csr_data_t exp, input logic exp_err);
    int stall;
    transfer(1'b0, addr, '0, exp, exp_err, stall);
  endtask

  task automatic write_reg(input csr_addr_t addr, input csr_data_t v, input logic exp_err);
    int stall;
    transfer(1'b1, addr, v, '0, exp_err, stall);
  endtask

  task automatic set_mie(input csr_data_t v);
    mdl_mie = v & impl_mask;
    write_reg(CSR_MIE, v, 1'b0);
  endtask

  task automatic load_mstatus(input csr_data_t v);
    mdl_m_ie  = v[3];
    mdl_m_pie = v[7];
    write_reg(CSR_MSTATUS, v, 1'b0);
  endtask

  task automatic expect_ack(input logic exp_take);
    logic seen;
    seen = 1'b0;
    for (int i = 0; i < ACK_WAIT && !seen; i++) begin
      @(negedge clk);
      seen = irq_ack;
    end
    // Step past the acknowledge cycle
    if (seen) begin
      @(negedge clk);
    end
    check_true(seen == exp_take, exp_take ? "No acknowledge within the wait window"
                                          : "Acknowledge seen with no takeable interrupt");
  endtask

  ////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////

  always @(negedge clk) begin
    ack_ref_t exp_ack;
    if (arst_n && irq_ack) begin
      exp_ack = predict_ack(irq, mdl_mie, mdl_m_ie);
      acks_seen++;
      check_true(exp_ack.take, "Acknowledge raised with no takeable interrupt");
      check_val("irq_id_o", 32'(exp_ack.id), 32'(irq_id));
      // Trap entry saves MIE to MPIE and clears it
      mdl_m_pie = mdl_m_ie;
      mdl_m_ie  = 1'b0;
    end
    if (csr_rvalid) begin
      responses++;
    end
  end

  initial begin
    #(CLK_PERIOD * (RESET_CYCLES + N_XFERS * XFER_CYCLES));
    $display("Watchdog expired before the tests finished");
    $display("Test FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    ack_ref_t exp_ack;
    int       stall;
    int       base;
    lcg_state = 32'hb9cb5539;
    for (int i = 0; i < 32; i++) begin
      impl_mask[i] = (i == 3) || (i == 7) || (i == 11) || (i >= 16);
    end
    arst_n          = 1'b0;
    irq             = '0;
    csr_req         = 1'b0;
    csr_req_payload = '0;
    mdl_mie         = '0;
    mdl_m_ie        = 1'b0;
    mdl_m_pie       = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    check_val("csr_gnt_o", 32'h0, 32'(csr_gnt));
    arst_n = 1'b1;
    @(negedge clk);
    check_val("csr_gnt_o", 32'h1, 32'(csr_gnt));
    // mie and mstatus read back masked with no lines pending
    for (int i = 0; i < N_RW; i++) begin
      set_mie(lcg_next());
      read_reg(CSR_MIE, mdl_mie, 1'b0);
      load_mstatus(lcg_next());
      read_reg(CSR_MSTATUS, mstatus_model(), 1'b0);
    end
    load_mstatus('0);
    // mip follows the lines and ignores writes while unknown numbers give err
    irq = lcg_next();
    repeat (2) @(negedge clk);
    read_reg(CSR_MIP, irq & impl_mask, 1'b0);
    write_reg(CSR_MIP, ~irq, 1'b0);
    read_reg(CSR_MIP, irq & impl_mask, 1'b0);
    read_reg(12'h305, '0, 1'b1);
    write_reg(12'h341, lcg_next(), 1'b1);
    read_reg(CSR_MIE, mdl_mie, 1'b0);
    // Priority with every fourth round lacking overlap
    for (int i = 0; i < N_PRIO; i++) begin
      load_mstatus('0);
      irq = (i % 4 == 1) ? (lcg_next() & 32'h0000_ffff) : lcg_next();
      set_mie((i % 4 == 0) ? ~irq : lcg_next());
      exp_ack = predict_ack(irq, mdl_mie, 1'b1);
      load_mstatus(32'h8);
      expect_ack(exp_ack.take);
    end
    // Trap entry with a read held off by the response and acknowledge cycles
    load_mstatus('0);
    irq = 32'h0000_0880;
    set_mie(32'h0000_0888);
    base = acks_seen;
    load_mstatus(32'h8);
    transfer(1'b0, CSR_MSTATUS, '0, 32'h0000_0080, 1'b0, stall);
    check_true(stall == 2, "Read was not held off for exactly two cycles");
    check_true(acks_seen == base + 1, "Trap entry did not give exactly one acknowledge");
    expect_ack(1'b0);
    load_mstatus(32'h8);
    expect_ack(1'b1);
    // Global disable with every line pending and enabled
    load_mstatus(32'h80);
    irq = '1;
    set_mie('1);
    expect_ack(1'b0);
    repeat (2) @(negedge clk);
    check_true(responses == xfers, "Response count differs from transfer count");
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
verilog/irq_pkg.sv
verilog/irq_pending.sv
verilog/irq_csr.sv
verilog/irq_controller.sv
verilog/irq_top.sv
tb/irq_properties.sv
tb/irq_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module irq_tb -f compile.f \
  && ./obj_dir/Virq_tb | tee /dev/stderr | grep -qx "Test OK" \
  && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
